// File: design/ra_flit_pkg.sv
/*
 * Flit format for the remote-access packetizer
 * Field widths, the packed flit and the flit type encoding
 */
package ra_flit_pkg;

	// Payload and header field widths
	localparam int DATA_WIDTH = 32;
	localparam int VC_BITS = 1;
	localparam int ID_BITS = 4;
	localparam int EXTRA_BITS = 2;
	localparam int TYPE_BITS = 2;
	localparam int FLIT_WIDTH = (2 * ID_BITS) + EXTRA_BITS + TYPE_BITS + VC_BITS + DATA_WIDTH;

	// One channel per VC field value
	localparam int VC_COUNT = 1 << VC_BITS;

	// HEAD and TAIL frame a two-flit message, ALL is a message by itself
	typedef enum logic [TYPE_BITS-1:0] {
		BODY = 2'd0,
		TAIL = 2'd1,
		HEAD = 2'd2,
		ALL  = 2'd3
	} flit_type_e;

	// Most significant field first
	typedef struct packed {
		logic [ID_BITS-1:0]    dest_id;
		logic [ID_BITS-1:0]    src_id;
		logic [EXTRA_BITS-1:0] sub_flow;
		flit_type_e            flit_type;
		logic [VC_BITS-1:0]    vc;
		logic [DATA_WIDTH-1:0] data;
	} flit_t;

	// One bit per virtual channel
	typedef logic [VC_COUNT-1:0] vc_mask_t;

endpackage

// File: design/ra_ctrl_pkg.sv
/*
 * State encodings for the cache reader, send arbiter and core delivery FSMs
 */
package ra_ctrl_pkg;

	// Cache read scan
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_CHECK_VC,
		RD_CHECK_AGAIN,
		RD_READ_DELAY,
		RD_READ,
		RD_WAIT_RESP
	} reader_state_e;

	// Outbound arbitration
	typedef enum logic [1:0] {
		SND_IDLE,
		SND_SEARCH,
		SND_READY,
		SND_READY2
	} send_state_e;

	// Processor delivery, second state only for a pending tail
	typedef enum logic {
		DLV_IDLE,
		DLV_TAIL
	} deliver_state_e;

endpackage

// File: design/ra_stage_if.sv
/*
 * Staged message bundle between a message stage and its consumer
 * Slot 0 holds HEAD or ALL, slot 1 holds TAIL
 */
`timescale 1ns/1ps

interface ra_stage_if;

	ra_flit_pkg::flit_t flit0;
	logic               v0;
	ra_flit_pkg::flit_t flit1;
	logic               v1;
	// Whole message present
	logic               ready;
	// One-cycle pulse from the consumer, empties both slots
	logic               release_pulse;

	modport producer (
		output flit0, v0, flit1, v1, ready,
		input  release_pulse
	);

	modport consumer (
		input  flit0, v0, flit1, v1, ready,
		output release_pulse
	);

endinterface

// File: design/ra_vc_buffer.sv
/*
 * Per-VC FIFOs holding cache-bound flits from the router
 * Registered read of the oldest flit of one channel, writes to a full channel are lost
 */
`timescale 1ns/1ps

module ra_vc_buffer #(
	parameter int VC_DEPTH_BITS = 4
) (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                write_en,
	input  ra_flit_pkg::flit_t                  write_flit,
	input  logic [ra_flit_pkg::VC_BITS-1:0]     write_vc,
	input  logic                                read_en,
	input  logic [ra_flit_pkg::VC_BITS-1:0]     read_vc,
	output ra_flit_pkg::flit_t                  read_flit,
	output logic                                read_valid,
	output ra_flit_pkg::vc_mask_t               empty,
	output ra_flit_pkg::vc_mask_t               full
);

	localparam int DEPTH = 1 << VC_DEPTH_BITS;
	localparam int VCS = ra_flit_pkg::VC_COUNT;

	// Oldest entry of each channel
	logic [ra_flit_pkg::FLIT_WIDTH-1:0] head_word [VCS];
	logic do_write;
	logic do_read;

	assign do_write = write_en & ~full[write_vc];
	assign do_read = read_en & ~empty[read_vc];

	for (genvar v = 0; v < VCS; v++) begin : g_chan
		logic [ra_flit_pkg::FLIT_WIDTH-1:0] mem [DEPTH];
		logic [VC_DEPTH_BITS-1:0] wr_ptr;
		logic [VC_DEPTH_BITS-1:0] rd_ptr;
		// One extra bit so a full channel is distinct from an empty one
		logic [VC_DEPTH_BITS:0] count;
		logic wr_hit;
		logic rd_hit;

		assign wr_hit = do_write && (write_vc == (ra_flit_pkg::VC_BITS)'(v));
		assign rd_hit = do_read && (read_vc == (ra_flit_pkg::VC_BITS)'(v));
		assign empty[v] = (count == '0);
		assign full[v] = (count == (VC_DEPTH_BITS + 1)'(DEPTH));
		assign head_word[v] = mem[rd_ptr];

		always_ff @(posedge clock) begin
			if (reset) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end else begin
				if (wr_hit)
					wr_ptr <= wr_ptr + 1'b1;
				if (rd_hit)
					rd_ptr <= rd_ptr + 1'b1;
				// Simultaneous write and read leaves the count alone
				case ({wr_hit, rd_hit})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end

		always_ff @(posedge clock) begin
			if (wr_hit)
				mem[wr_ptr] <= write_flit;
		end
	end

	// Flit appears the cycle after read_en
	always_ff @(posedge clock) begin
		if (reset)
			read_valid <= 1'b0;
		else
			read_valid <= do_read;
	end

	always_ff @(posedge clock) begin
		if (do_read)
			read_flit <= ra_flit_pkg::flit_t'(head_word[read_vc]);
	end

endmodule

// File: design/ra_msg_stage.sv
/*
 * Two-slot message holding register
 * Sorts flits into slots by type and flags a complete message
 */
`timescale 1ns/1ps

module ra_msg_stage (
	input  logic               clock,
	input  logic               reset,
	input  ra_flit_pkg::flit_t flit_in,
	input  logic               flit_valid,
	ra_stage_if.producer       stage
);

	logic load0;
	logic load1;
	logic load_last;

	// HEAD or ALL go to slot 0, TAIL to slot 1, BODY is ignored
	assign load0 = flit_valid &&
		((flit_in.flit_type == ra_flit_pkg::HEAD) || (flit_in.flit_type == ra_flit_pkg::ALL));
	assign load1 = flit_valid && (flit_in.flit_type == ra_flit_pkg::TAIL);
	assign load_last = flit_valid &&
		((flit_in.flit_type == ra_flit_pkg::ALL) || (flit_in.flit_type == ra_flit_pkg::TAIL));

	// A load wins over a release in the same cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			stage.v0 <= 1'b0;
			stage.v1 <= 1'b0;
			stage.ready <= 1'b0;
		end else begin
			stage.v0 <= load0 ? 1'b1 : (stage.release_pulse ? 1'b0 : stage.v0);
			stage.v1 <= load1 ? 1'b1 : (stage.release_pulse ? 1'b0 : stage.v1);
			stage.ready <= load_last ? 1'b1 : (stage.release_pulse ? 1'b0 : stage.ready);
		end
	end

	always_ff @(posedge clock) begin
		if (load0)
			stage.flit0 <= flit_in;
		if (load1)
			stage.flit1 <= flit_in;
	end

endmodule

// File: design/ra_cache_reader.sv
/*
 * Cache read scan over the VC buffers
 * Hands each flit to the cache, then waits for the cache reply to go out
 */
`timescale 1ns/1ps

module ra_cache_reader (
	input  logic                            clock,
	input  logic                            reset,
	input  ra_flit_pkg::vc_mask_t           empty,
	output logic                            read_en,
	output logic [ra_flit_pkg::VC_BITS-1:0] read_vc,
	input  ra_flit_pkg::flit_t              read_flit,
	input  logic                            read_valid,
	input  logic                            cache_sent,
	output ra_flit_pkg::flit_t              c_flit_received,
	output logic                            cv_rec_flit,
	output logic                            c_ready
);

	ra_ctrl_pkg::reader_state_e state;
	// Channel under scan
	logic [ra_flit_pkg::VC_BITS-1:0] cur_vc;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ra_ctrl_pkg::RD_IDLE;
			cur_vc <= '0;
			read_en <= 1'b0;
			read_vc <= '0;
			cv_rec_flit <= 1'b0;
			c_ready <= 1'b0;
		end else begin
			case (state)
				ra_ctrl_pkg::RD_IDLE: begin
					// Rotate to the next channel, wraps on its own
					cur_vc <= cur_vc + 1'b1;
					c_ready <= 1'b0;
					state <= ra_ctrl_pkg::RD_CHECK_VC;
				end
				ra_ctrl_pkg::RD_CHECK_VC: begin
					if (!empty[cur_vc]) begin
						read_en <= 1'b1;
						read_vc <= cur_vc;
						state <= ra_ctrl_pkg::RD_READ_DELAY;
					end else begin
						state <= ra_ctrl_pkg::RD_IDLE;
					end
				end
				ra_ctrl_pkg::RD_CHECK_AGAIN: begin
					// Rest of a HEAD message is expected on the same channel
					cv_rec_flit <= 1'b0;
					if (!empty[cur_vc]) begin
						read_en <= 1'b1;
						read_vc <= cur_vc;
						state <= ra_ctrl_pkg::RD_READ_DELAY;
					end
				end
				ra_ctrl_pkg::RD_READ_DELAY: begin
					read_en <= 1'b0;
					state <= ra_ctrl_pkg::RD_READ;
				end
				ra_ctrl_pkg::RD_READ: begin
					if (read_valid) begin
						cv_rec_flit <= 1'b1;
						c_ready <= 1'b1;
						if (read_flit.flit_type == ra_flit_pkg::HEAD)
							state <= ra_ctrl_pkg::RD_CHECK_AGAIN;
						else
							state <= ra_ctrl_pkg::RD_WAIT_RESP;
					end
				end
				ra_ctrl_pkg::RD_WAIT_RESP: begin
					cv_rec_flit <= 1'b0;
					// Cache reply has left the arbiter
					if (cache_sent)
						state <= ra_ctrl_pkg::RD_IDLE;
				end
				default: state <= ra_ctrl_pkg::RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == ra_ctrl_pkg::RD_READ) && read_valid)
			c_flit_received <= read_flit;
	end

endmodule

// File: design/ra_core_deliver.sv
/*
 * Processor delivery of an assembled inbound message
 * Head or single flit first, a tail on the following cycle
 */
`timescale 1ns/1ps

module ra_core_deliver (
	input  logic               clock,
	input  logic               reset,
	ra_stage_if.consumer       inbound,
	output ra_flit_pkg::flit_t p_flit_received,
	output logic               pv_rec_flit,
	output logic               p_ready
);

	ra_ctrl_pkg::deliver_state_e state;
	// Tail copy so the stage can refill right away
	ra_flit_pkg::flit_t tail_hold;

	assign inbound.release_pulse = (state == ra_ctrl_pkg::DLV_IDLE) && inbound.ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ra_ctrl_pkg::DLV_IDLE;
			pv_rec_flit <= 1'b0;
			p_ready <= 1'b1;
		end else begin
			case (state)
				ra_ctrl_pkg::DLV_IDLE: begin
					pv_rec_flit <= inbound.ready && inbound.v0;
					// Low while the tail is still owed
					p_ready <= !(inbound.ready && inbound.v1);
					if (inbound.ready && inbound.v1)
						state <= ra_ctrl_pkg::DLV_TAIL;
				end
				ra_ctrl_pkg::DLV_TAIL: begin
					pv_rec_flit <= 1'b1;
					p_ready <= 1'b1;
					state <= ra_ctrl_pkg::DLV_IDLE;
				end
				default: state <= ra_ctrl_pkg::DLV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == ra_ctrl_pkg::DLV_IDLE) && inbound.ready) begin
			p_flit_received <= inbound.flit0;
			tail_hold <= inbound.flit1;
		end else if (state == ra_ctrl_pkg::DLV_TAIL) begin
			p_flit_received <= tail_hold;
		end
	end

endmodule

// File: design/ra_send_arbiter.sv
/*
 * Outbound arbiter toward the router port
 * Finds a free VC, sends the cache message first, rewrites the VC field
 */
`timescale 1ns/1ps

module ra_send_arbiter (
	input  logic                  clock,
	input  logic                  reset,
	ra_stage_if.consumer          cache_out,
	ra_stage_if.consumer          proc_out,
	input  ra_flit_pkg::vc_mask_t to_core_empty,
	output ra_flit_pkg::flit_t    from_core_flit,
	output logic                  v_from_core,
	output logic                  cache_sent
);

	ra_ctrl_pkg::send_state_e state;
	logic [ra_flit_pkg::VC_BITS-1:0] free_vc;
	logic [ra_flit_pkg::VC_BITS-1:0] high_vc;
	// Source of the pending second flit, 1 for the processor
	logic send_proc;
	logic cache_go;
	logic proc_go;

	function automatic ra_flit_pkg::flit_t set_vc(
		input ra_flit_pkg::flit_t f,
		input logic [ra_flit_pkg::VC_BITS-1:0] vc
	);
		ra_flit_pkg::flit_t r;
		r = f;
		r.vc = vc;
		return r;
	endfunction

	// Highest channel with room at the router
	always_comb begin
		high_vc = '0;
		for (int v = 0; v < ra_flit_pkg::VC_COUNT; v++) begin
			if (to_core_empty[v])
				high_vc = (ra_flit_pkg::VC_BITS)'(v);
		end
	end

	// Cache has priority over the processor
	assign cache_go = (state == ra_ctrl_pkg::SND_READY) && cache_out.ready;
	assign proc_go = (state == ra_ctrl_pkg::SND_READY) && !cache_out.ready && proc_out.ready;

	// Release with the last flit of the message
	assign cache_out.release_pulse = (cache_go && !cache_out.v1) ||
		((state == ra_ctrl_pkg::SND_READY2) && !send_proc);
	assign proc_out.release_pulse = (proc_go && !proc_out.v1) ||
		((state == ra_ctrl_pkg::SND_READY2) && send_proc);
	assign cache_sent = cache_out.release_pulse;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ra_ctrl_pkg::SND_IDLE;
			free_vc <= '0;
			send_proc <= 1'b0;
			v_from_core <= 1'b0;
		end else begin
			v_from_core <= 1'b0;
			case (state)
				ra_ctrl_pkg::SND_IDLE: state <= ra_ctrl_pkg::SND_SEARCH;
				ra_ctrl_pkg::SND_SEARCH: begin
					// Held here while the router has no free VC
					if (|to_core_empty) begin
						free_vc <= high_vc;
						state <= ra_ctrl_pkg::SND_READY;
					end
				end
				ra_ctrl_pkg::SND_READY: begin
					if (cache_go || proc_go) begin
						v_from_core <= 1'b1;
						send_proc <= proc_go;
						if ((cache_go && cache_out.v1) || (proc_go && proc_out.v1))
							state <= ra_ctrl_pkg::SND_READY2;
						else
							state <= ra_ctrl_pkg::SND_IDLE;
					end
				end
				ra_ctrl_pkg::SND_READY2: begin
					v_from_core <= 1'b1;
					state <= ra_ctrl_pkg::SND_IDLE;
				end
				default: state <= ra_ctrl_pkg::SND_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (cache_go)
			from_core_flit <= set_vc(cache_out.flit0, free_vc);
		else if (proc_go)
			from_core_flit <= set_vc(proc_out.flit0, free_vc);
		else if (state == ra_ctrl_pkg::SND_READY2)
			from_core_flit <= set_vc(send_proc ? proc_out.flit1 : cache_out.flit1, free_vc);
	end

endmodule

// File: design/ra_packetizer.sv
/*
 * Remote-access packetizer between one cache, one processor and a router port
 * Sorts inbound flits by sub-flow and ties the staging, buffering and send logic
 */
`timescale 1ns/1ps

module ra_packetizer #(
	parameter int VC_DEPTH_BITS = 4
) (
	input  logic                  clock,
	input  logic                  reset,
	input  ra_flit_pkg::flit_t    c_flit_to_send,
	input  logic                  cv_send_flit,
	output ra_flit_pkg::flit_t    c_flit_received,
	output logic                  cv_rec_flit,
	output logic                  c_ready,
	input  ra_flit_pkg::flit_t    p_flit_to_send,
	input  logic                  pv_send_flit,
	output ra_flit_pkg::flit_t    p_flit_received,
	output logic                  pv_rec_flit,
	output logic                  p_ready,
	output ra_flit_pkg::flit_t    from_core_flit,
	output logic                  v_from_core,
	output ra_flit_pkg::vc_mask_t from_core_empty,
	output ra_flit_pkg::vc_mask_t from_core_full,
	input  ra_flit_pkg::flit_t    to_core_flit,
	input  logic                  v_to_core,
	input  ra_flit_pkg::vc_mask_t to_core_empty
);

	ra_stage_if cache_out_if ();
	ra_stage_if proc_out_if ();
	ra_stage_if core_in_if ();

	logic cache_traffic;
	logic core_traffic;
	logic buf_write_en;
	ra_flit_pkg::flit_t buf_write_flit;
	logic [ra_flit_pkg::VC_BITS-1:0] buf_write_vc;
	logic buf_read_en;
	logic [ra_flit_pkg::VC_BITS-1:0] buf_read_vc;
	ra_flit_pkg::flit_t buf_read_flit;
	logic buf_read_valid;
	logic cache_sent;

	// Sub-flow 0 or 1 is cache traffic, 2 or 3 is core traffic
	assign cache_traffic = v_to_core && !to_core_flit.sub_flow[1];
	assign core_traffic = v_to_core && to_core_flit.sub_flow[1];

	// Buffer write lands one cycle after arrival
	always_ff @(posedge clock) begin
		if (reset)
			buf_write_en <= 1'b0;
		else
			buf_write_en <= cache_traffic;
	end

	always_ff @(posedge clock) begin
		buf_write_flit <= to_core_flit;
		buf_write_vc <= to_core_flit.vc;
	end

	ra_vc_buffer #(
		.VC_DEPTH_BITS(VC_DEPTH_BITS)
	) u_vc_buffer (
		.clock      (clock),
		.reset      (reset),
		.write_en   (buf_write_en),
		.write_flit (buf_write_flit),
		.write_vc   (buf_write_vc),
		.read_en    (buf_read_en),
		.read_vc    (buf_read_vc),
		.read_flit  (buf_read_flit),
		.read_valid (buf_read_valid),
		.empty      (from_core_empty),
		.full       (from_core_full)
	);

	// Outbound stages fed straight from the cache and processor
	ra_msg_stage u_cache_stage (
		.clock      (clock),
		.reset      (reset),
		.flit_in    (c_flit_to_send),
		.flit_valid (cv_send_flit),
		.stage      (cache_out_if.producer)
	);

	ra_msg_stage u_proc_stage (
		.clock      (clock),
		.reset      (reset),
		.flit_in    (p_flit_to_send),
		.flit_valid (pv_send_flit),
		.stage      (proc_out_if.producer)
	);

	ra_msg_stage u_core_in_stage (
		.clock      (clock),
		.reset      (reset),
		.flit_in    (to_core_flit),
		.flit_valid (core_traffic),
		.stage      (core_in_if.producer)
	);

	ra_cache_reader u_cache_reader (
		.clock           (clock),
		.reset           (reset),
		.empty           (from_core_empty),
		.read_en         (buf_read_en),
		.read_vc         (buf_read_vc),
		.read_flit       (buf_read_flit),
		.read_valid      (buf_read_valid),
		.cache_sent      (cache_sent),
		.c_flit_received (c_flit_received),
		.cv_rec_flit     (cv_rec_flit),
		.c_ready         (c_ready)
	);

	ra_core_deliver u_core_deliver (
		.clock           (clock),
		.reset           (reset),
		.inbound         (core_in_if.consumer),
		.p_flit_received (p_flit_received),
		.pv_rec_flit     (pv_rec_flit),
		.p_ready         (p_ready)
	);

	ra_send_arbiter u_send_arbiter (
		.clock          (clock),
		.reset          (reset),
		.cache_out      (cache_out_if.consumer),
		.proc_out       (proc_out_if.consumer),
		.to_core_empty  (to_core_empty),
		.from_core_flit (from_core_flit),
		.v_from_core    (v_from_core),
		.cache_sent     (cache_sent)
	);

endmodule

// File: tb/ra_packetizer_props.sv
/*
 * Concurrent assertions on the packetizer outputs, bound into the top level
 */
`timescale 1ns/1ps

module ra_packetizer_props (
	input logic clock,
	input logic reset,
	input logic v_from_core,
	input logic cv_rec_flit,
	input logic pv_rec_flit
);

	// Failure count, read back by the testbench
	int fail_count = 0;

	// At most two flits per message, so never three in a row
	a_send_run: assert property (@(posedge clock) disable iff (reset)
		!(v_from_core && $past(v_from_core) && $past(v_from_core, 2)))
	else begin
		fail_count++;
		$error("v_from_core high for three cycles running");
	end

	// Cache delivery strobe lasts one cycle
	a_cache_pulse: assert property (@(posedge clock) disable iff (reset)
		cv_rec_flit |=> !cv_rec_flit)
	else begin
		fail_count++;
		$error("cv_rec_flit longer than one cycle");
	end

	// Quiet outputs once reset has taken hold
	a_reset_quiet: assert property (@(posedge clock)
		(reset && $past(reset)) |-> (!cv_rec_flit && !pv_rec_flit && !v_from_core))
	else begin
		fail_count++;
		$error("output strobe during reset");
	end

endmodule

bind ra_packetizer ra_packetizer_props u_props (.*);

// File: tb/ra_checker.sv
/*
 * Output monitor for the packetizer
 * Compares delivered and sent flits with queued expected flits
 */
`timescale 1ns/1ps

module ra_checker #(
	parameter int DEPTH = 16
) (
	input logic                  clock,
	input logic                  reset,
	input ra_flit_pkg::flit_t    c_flit_received,
	input logic                  cv_rec_flit,
	input logic                  c_ready,
	input ra_flit_pkg::flit_t    p_flit_received,
	input logic                  pv_rec_flit,
	input logic                  p_ready,
	input ra_flit_pkg::flit_t    from_core_flit,
	input logic                  v_from_core,
	input ra_flit_pkg::vc_mask_t from_core_empty,
	input ra_flit_pkg::vc_mask_t from_core_full
);

	ra_flit_pkg::flit_t cache_q[$];
	ra_flit_pkg::flit_t proc_q[$];
	ra_flit_pkg::flit_t send_q[$];
	int error_count = 0;
	int match_count = 0;
	logic prev_reset = 1'b0;
	// Cache flits per channel not yet delivered
	int cache_owed [ra_flit_pkg::VC_COUNT];
	// Set after a cache delivery until the cache reply leaves
	logic reply_owed = 1'b0;
	// Set after an outbound HEAD, its TAIL must follow at once
	logic tail_due = 1'b0;
	ra_flit_pkg::flit_t exp_flit;

	task automatic expect_cache(input ra_flit_pkg::flit_t f);
		cache_q.push_back(f);
		cache_owed[f.vc]++;
	endtask

	task automatic expect_proc(input ra_flit_pkg::flit_t f);
		proc_q.push_back(f);
	endtask

	task automatic expect_send(input ra_flit_pkg::flit_t f);
		send_q.push_back(f);
	endtask

	// Flits still owed by the DUT
	function automatic int pending();
		return cache_q.size() + proc_q.size() + send_q.size();
	endfunction

	task automatic compare_flit(input string what, input ra_flit_pkg::flit_t got,
		input ra_flit_pkg::flit_t exp);
		if (got !== exp) begin
			error_count++;
			$display("ERR @%0t: %s flit got %h expected %h", $time, what, got, exp);
		end else begin
			match_count++;
		end
	endtask

	always @(posedge clock) begin
		// First edge after reset still shows the reset values
		if (prev_reset && !reset) begin
			if (cv_rec_flit || pv_rec_flit || v_from_core || c_ready || !p_ready) begin
				error_count++;
				$display("ERR @%0t: outputs not at reset values", $time);
			end
		end
		prev_reset = reset;
		if (!reset) begin
			// Buffer occupancy follows the cache flits still owed
			for (int v = 0; v < ra_flit_pkg::VC_COUNT; v++) begin
				if (cache_owed[v] == 0 && from_core_empty[v] !== 1'b1) begin
					error_count++;
					$display("ERR @%0t: VC %0d not empty with no cache flit owed", $time, v);
				end
				if (cache_owed[v] < DEPTH && from_core_full[v] !== 1'b0) begin
					error_count++;
					$display("ERR @%0t: VC %0d full with %0d flits owed", $time, v,
						cache_owed[v]);
				end
			end
			if (cv_rec_flit) begin
				if (reply_owed) begin
					error_count++;
					$display("Cache flit delivered at %0t before the cache reply left", $time);
				end
				if (cache_q.size() == 0) begin
					error_count++;
					$display("Unexpected flit delivered to the cache at %0t", $time);
				end else begin
					exp_flit = cache_q.pop_front();
					cache_owed[exp_flit.vc]--;
					compare_flit("cache", c_flit_received, exp_flit);
					// Anything but a HEAD waits for the cache reply
					reply_owed = (exp_flit.flit_type != ra_flit_pkg::HEAD);
				end
			end
			if (pv_rec_flit) begin
				if (proc_q.size() == 0) begin
					error_count++;
					$display("Unexpected flit delivered to the processor at %0t", $time);
				end else
					compare_flit("processor", p_flit_received, proc_q.pop_front());
			end
			if (tail_due && !v_from_core) begin
				error_count++;
				$display("Second flit of a message not sent on the next cycle at %0t", $time);
			end
			tail_due = 1'b0;
			if (v_from_core) begin
				if (send_q.size() == 0) begin
					error_count++;
					$display("Unexpected flit sent to the router at %0t", $time);
				end else begin
					exp_flit = send_q.pop_front();
					tail_due = (exp_flit.flit_type == ra_flit_pkg::HEAD);
					// Sub-flow 0 or 1 marks a cache reply
					if (!exp_flit.sub_flow[1])
						reply_owed = 1'b0;
					compare_flit("router", from_core_flit, exp_flit);
				end
			end
		end
	end

endmodule

// File: tb/tb_ra_packetizer.sv
/*
 * Testbench for the remote-access packetizer
 * Applies a stimulus table on the falling edge and reports the error counts
 */
`timescale 1ns/1ps

module tb_ra_packetizer;

	localparam int NUM_ROWS = 11;
	localparam int CYCLE_LIMIT = 200 * NUM_ROWS;
	localparam int VC_DEPTH_BITS = 4;

	// One table row, inputs then expected outputs
	typedef struct packed {
		logic r_v;
		ra_flit_pkg::flit_t r_flit;
		logic c_v;
		ra_flit_pkg::flit_t c_flit;
		logic p_v;
		ra_flit_pkg::flit_t p_flit;
		ra_flit_pkg::vc_mask_t tce;
		logic exp_c_v;
		ra_flit_pkg::flit_t exp_c;
		logic exp_p_v;
		ra_flit_pkg::flit_t exp_p;
		logic [1:0] exp_f_n;
		ra_flit_pkg::flit_t exp_f0;
		ra_flit_pkg::flit_t exp_f1;
		int idle;
		int wait_left;
	} row_t;

	logic clock;
	logic reset;
	ra_flit_pkg::flit_t c_flit_to_send;
	logic cv_send_flit;
	ra_flit_pkg::flit_t c_flit_received;
	logic cv_rec_flit;
	logic c_ready;
	ra_flit_pkg::flit_t p_flit_to_send;
	logic pv_send_flit;
	ra_flit_pkg::flit_t p_flit_received;
	logic pv_rec_flit;
	logic p_ready;
	ra_flit_pkg::flit_t from_core_flit;
	logic v_from_core;
	ra_flit_pkg::vc_mask_t from_core_empty;
	ra_flit_pkg::vc_mask_t from_core_full;
	ra_flit_pkg::flit_t to_core_flit;
	logic v_to_core;
	ra_flit_pkg::vc_mask_t to_core_empty;

	row_t rows [NUM_ROWS];
	logic [15:0] lfsr_state = 16'd88;
	int cycle_count = 0;
	int total_errors;

	ra_packetizer #(
		.VC_DEPTH_BITS(VC_DEPTH_BITS)
	) u_dut (.*);

	ra_checker #(
		.DEPTH(1 << VC_DEPTH_BITS)
	) u_check (
		.clock           (clock),
		.reset           (reset),
		.c_flit_received (c_flit_received),
		.cv_rec_flit     (cv_rec_flit),
		.c_ready         (c_ready),
		.p_flit_received (p_flit_received),
		.pv_rec_flit     (pv_rec_flit),
		.p_ready         (p_ready),
		.from_core_flit  (from_core_flit),
		.v_from_core     (v_from_core),
		.from_core_empty (from_core_empty),
		.from_core_full  (from_core_full)
	);

	// Galois LFSR, one step per bit
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
		end
		return v;
	endfunction

	function automatic ra_flit_pkg::flit_t make_flit(input logic [1:0] sub,
		input ra_flit_pkg::flit_type_e kind, input logic vc);
		ra_flit_pkg::flit_t f;
		f.dest_id = 4'h3;
		f.src_id = 4'h9;
		f.sub_flow = sub;
		f.flit_type = kind;
		f.vc = vc;
		f.data = next_bits(32);
		return f;
	endfunction

	// Outbound VC is the highest free channel at the router
	function automatic ra_flit_pkg::flit_t route_vc(input ra_flit_pkg::flit_t f,
		input ra_flit_pkg::vc_mask_t mask);
		ra_flit_pkg::flit_t r;
		r = f;
		for (int v = 0; v < ra_flit_pkg::VC_COUNT; v++)
			if (mask[v])
				r.vc = v[0];
		return r;
	endfunction

	function automatic row_t blank_row(input ra_flit_pkg::vc_mask_t tce, input int wait_left);
		row_t r;
		r = '0;
		r.tce = tce;
		r.wait_left = wait_left;
		return r;
	endfunction

	task automatic build_table();
		ra_flit_pkg::flit_t head;
		ra_flit_pkg::flit_t tail;
		// Single core flit, then a core HEAD and TAIL pair
		rows[0] = blank_row(2'b10, 0);
		rows[0].r_v = 1'b1;
		rows[0].r_flit = make_flit(2'd2, ra_flit_pkg::ALL, 1'b0);
		rows[0].exp_p_v = 1'b1;
		rows[0].exp_p = rows[0].r_flit;
		rows[1] = blank_row(2'b10, -1);
		rows[1].r_v = 1'b1;
		rows[1].r_flit = make_flit(2'd3, ra_flit_pkg::HEAD, 1'b1);
		rows[1].exp_p_v = 1'b1;
		rows[1].exp_p = rows[1].r_flit;
		rows[2] = blank_row(2'b10, 0);
		rows[2].r_v = 1'b1;
		rows[2].r_flit = make_flit(2'd3, ra_flit_pkg::TAIL, 1'b1);
		rows[2].exp_p_v = 1'b1;
		rows[2].exp_p = rows[2].r_flit;
		// Two cache flits on VC 0, each answered by a cache reply
		for (int i = 3; i < 5; i++) begin
			rows[i] = blank_row(2'b10, (i == 3) ? -1 : 1);
			rows[i].r_v = 1'b1;
			rows[i].r_flit = make_flit(2'd0, ra_flit_pkg::ALL, 1'b0);
			rows[i].exp_c_v = 1'b1;
			rows[i].exp_c = rows[i].r_flit;
		end
		// Each reply goes out after the delivery it answers
		for (int i = 5; i < 7; i++) begin
			rows[i] = blank_row(2'b10, 0);
			rows[i].c_v = 1'b1;
			rows[i].c_flit = make_flit(2'd1, ra_flit_pkg::ALL, 1'b0);
			rows[i].exp_f_n = 2'd1;
			rows[i].exp_f0 = route_vc(rows[i].c_flit, rows[i].tce);
		end
		// Processor pair held with no free VC, then let go
		head = make_flit(2'd2, ra_flit_pkg::HEAD, 1'b0);
		tail = make_flit(2'd2, ra_flit_pkg::TAIL, 1'b0);
		rows[7] = blank_row(2'b00, -1);
		rows[7].p_v = 1'b1;
		rows[7].p_flit = head;
		rows[8] = blank_row(2'b00, -1);
		rows[8].p_v = 1'b1;
		rows[8].p_flit = tail;
		rows[8].idle = 8;
		rows[9] = blank_row(2'b01, 0);
		rows[9].exp_f_n = 2'd2;
		rows[9].exp_f0 = route_vc(head, 2'b01);
		rows[9].exp_f1 = route_vc(tail, 2'b01);
		// Cache and processor staged together, cache goes first
		rows[10] = blank_row(2'b01, 0);
		rows[10].c_v = 1'b1;
		rows[10].c_flit = make_flit(2'd0, ra_flit_pkg::ALL, 1'b1);
		rows[10].p_v = 1'b1;
		rows[10].p_flit = make_flit(2'd3, ra_flit_pkg::ALL, 1'b0);
		rows[10].exp_f_n = 2'd2;
		rows[10].exp_f0 = route_vc(rows[10].c_flit, 2'b01);
		rows[10].exp_f1 = route_vc(rows[10].p_flit, 2'b01);
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: no finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		c_flit_to_send = '0;
		cv_send_flit = 1'b0;
		p_flit_to_send = '0;
		pv_send_flit = 1'b0;
		to_core_flit = '0;
		v_to_core = 1'b0;
		to_core_empty = 2'b10;
		build_table();
		repeat (5) @(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);
		for (int i = 0; i < NUM_ROWS; i++) begin
			to_core_empty = rows[i].tce;
			v_to_core = rows[i].r_v;
			to_core_flit = rows[i].r_flit;
			cv_send_flit = rows[i].c_v;
			c_flit_to_send = rows[i].c_flit;
			pv_send_flit = rows[i].p_v;
			p_flit_to_send = rows[i].p_flit;
			if (rows[i].exp_c_v)
				u_check.expect_cache(rows[i].exp_c);
			if (rows[i].exp_p_v)
				u_check.expect_proc(rows[i].exp_p);
			if (rows[i].exp_f_n > 0)
				u_check.expect_send(rows[i].exp_f0);
			if (rows[i].exp_f_n > 1)
				u_check.expect_send(rows[i].exp_f1);
			@(negedge clock);
			v_to_core = 1'b0;
			cv_send_flit = 1'b0;
			pv_send_flit = 1'b0;
			repeat (rows[i].idle) @(negedge clock);
			// Wait until few enough flits are still owed
			while (rows[i].wait_left >= 0 && u_check.pending() > rows[i].wait_left)
				@(negedge clock);
		end
		repeat (4) @(negedge clock);
		total_errors = u_check.error_count + u_dut.u_props.fail_count;
		$display("Matched %0d, errors %0d, assertion failures %0d",
			u_check.match_count, u_check.error_count, u_dut.u_props.fail_count);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
design/ra_flit_pkg.sv
design/ra_ctrl_pkg.sv
design/ra_stage_if.sv
design/ra_vc_buffer.sv
design/ra_msg_stage.sv
design/ra_cache_reader.sv
design/ra_core_deliver.sv
design/ra_send_arbiter.sv
design/ra_packetizer.sv
tb/ra_packetizer_props.sv
tb/ra_checker.sv
tb/tb_ra_packetizer.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
TOP        = tb_ra_packetizer
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TB FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
